//--- build.f
src/vec_pkg.sv
src/sync_fifo.sv
src/op_dispatch.sv
src/dot_unit.sv
src/cross_unit.sv
src/result_arbiter.sv
src/vec_engine.sv
sim/vec_engine_properties.sv
sim/vec_engine_tb.sv

//--- Bender.yml
package:
  name: vec_engine

sources:
  - src/vec_pkg.sv
  - src/sync_fifo.sv
  - src/op_dispatch.sv
  - src/dot_unit.sv
  - src/cross_unit.sv
  - src/result_arbiter.sv
  - src/vec_engine.sv
  - target: simulation
    files:
      - sim/vec_engine_properties.sv
      - sim/vec_engine_tb.sv

//--- sim/vec_engine_tb.sv
module vec_engine_tb import vec_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int Q_BITS = 10;

    logic        clock = 1'b0;
    logic        reset;
    vec_cmd_t    cmd_in;
    logic        cmd_wr_en;
    logic        cmd_full;
    vec_result_t result_out;
    logic        result_rd_en;
    logic        result_empty;

    vec_result_t expected [256];    // scoreboard by tag
    bit          outstanding [256];
    logic [7:0]  order_q [2][$];    // tags in command order, per opcode
    logic [7:0]  next_tag = 0;
    string       test_name = "reset";
    int unsigned mismatches = 0;
    int unsigned other_errors = 0;
    int unsigned cycles = 0;
    int unsigned sent = 0;

    vec_engine #(.Q_BITS(Q_BITS), .FIFO_DEPTH(16)) dut (
        .clock(clock), .reset(reset),
        .cmd_in(cmd_in), .cmd_wr_en(cmd_wr_en), .cmd_full(cmd_full),
        .result_out(result_out), .result_rd_en(result_rd_en), .result_empty(result_empty)
    );

    initial begin
        forever #4 clock = ~clock;
    end

    // budget grows with every command sent
    always @(posedge clock) begin
        cycles++;
        if (cycles > 30 * sent + 500) begin
            $display("timeout after %0d cycles in %s", cycles, test_name);
            $display("sim failed");
            $finish;
        end
    end

    function automatic q_t fx_mul(input q_t a, input q_t b);
        longint full;
        full = longint'(a) * longint'(b);
        return q_t'(full >>> Q_BITS);   // floor toward minus infinity
    endfunction

    function automatic vec_result_t model(input vec_cmd_t c);
        vec_result_t r;
        r.op  = c.op;
        r.tag = c.tag;
        if (c.op == OP_DOT) begin
            r.value.x = fx_mul(c.a.x, c.b.x) + fx_mul(c.a.y, c.b.y) + fx_mul(c.a.z, c.b.z);
            r.value.y = '0;
            r.value.z = '0;
        end else begin
            r.value.x = fx_mul(c.a.y, c.b.z) - fx_mul(c.a.z, c.b.y);
            r.value.y = fx_mul(c.a.z, c.b.x) - fx_mul(c.a.x, c.b.z);
            r.value.z = fx_mul(c.a.x, c.b.y) - fx_mul(c.a.y, c.b.x);
        end
        return r;
    endfunction

    function automatic vec3_t v3(input q_t x, input q_t y, input q_t z);
        vec3_t v;
        v.x = x;
        v.y = y;
        v.z = z;
        return v;
    endfunction

    function automatic vec3_t rand_vec();
        return v3(q_t'($urandom_range(0, 32'h1f_ffff)) - q_t'(32'h10_0000),
                  q_t'($urandom_range(0, 32'h1f_ffff)) - q_t'(32'h10_0000),
                  q_t'($urandom_range(0, 32'h1f_ffff)) - q_t'(32'h10_0000));
    endfunction

    function automatic vec_op_e rand_op();
        return $urandom_range(0, 1) ? OP_CROSS : OP_DOT;
    endfunction

    function automatic void clear_scoreboard();
        foreach (outstanding[i]) outstanding[i] = 1'b0;
        order_q[0].delete();
        order_q[1].delete();
    endfunction

    task automatic check_result(input string what, input vec_result_t exp, input vec_result_t act);
        if (act !== exp) begin
            mismatches++;
            $display("MISMATCH %s tag %0d: expected %h, actual %h", what, exp.tag, exp, act);
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            mismatches++;
            $display("MISMATCH %s: expected %b, actual %b", what, exp, act);
        end
    endtask

    task automatic apply_reset();
        reset        = 1'b1;
        cmd_wr_en    = 1'b0;
        result_rd_en = 1'b0;
        repeat (3) @(negedge clock);
        reset = 1'b0;
    endtask

    // called and returns on a falling edge
    task automatic send(input vec_op_e op, input vec3_t a, input vec3_t b);
        vec_cmd_t c;
        c.op  = op;
        c.tag = next_tag;
        c.a   = a;
        c.b   = b;
        next_tag++;
        while (cmd_full) @(negedge clock);
        expected[c.tag]    = model(c);
        outstanding[c.tag] = 1'b1;
        order_q[op].push_back(c.tag);
        sent++;
        cmd_in    = c;
        cmd_wr_en = 1'b1;
        @(negedge clock);
        cmd_wr_en = 1'b0;
    endtask

    task automatic score(input vec_result_t r);
        int i;
        if (!outstanding[r.tag]) begin
            other_errors++;
            $display("%s: result with tag %0d was not expected or came twice", test_name, r.tag);
            return;
        end
        outstanding[r.tag] = 1'b0;
        check_result(test_name, expected[r.tag], r);
        if (order_q[r.op].size() == 0 || order_q[r.op][0] != r.tag) begin
            other_errors++;
            $display("%s: tag %0d left out of command order", test_name, r.tag);
        end
        for (i = 0; i < order_q[r.op].size(); i++) begin
            if (order_q[r.op][i] == r.tag) begin
                order_q[r.op].delete(i);
                break;
            end
        end
    endtask

    task automatic drain(input int n);
        int got;
        got = 0;
        while (got < n) begin
            result_rd_en = 1'b0;
            if (!result_empty) begin
                score(result_out);
                result_rd_en = 1'b1;    // pops on the next rising edge
                got++;
            end
            @(negedge clock);
        end
        result_rd_en = 1'b0;
        repeat (4) @(negedge clock);
        check_flag({test_name, " no extra results"}, 1'b1, result_empty);
    endtask

    task automatic dot_directed();
        test_name = "dot_directed";
        send(OP_DOT, v3(1536, -2304, 1), v3(-2048, 512, 1));
        send(OP_DOT, v3(-1, 0, 0), v3(1, 0, 0));           // -1/1024 floors to -1
        send(OP_DOT, v3(-3, 5, 7), v3(7, -3, 1));
        send(OP_DOT, v3(32'h7fff_ffff, 32'h8000_0000, 1024), v3(1024, 1024, 32'h7fff_ffff));
        drain(4);
    endtask

    task automatic cross_directed();
        test_name = "cross_directed";
        send(OP_CROSS, v3(1024, 0, 0), v3(0, 1024, 0));
        send(OP_CROSS, v3(2048, 4096, 6144), v3(1024, 2048, 3072));   // parallel
        send(OP_CROSS, v3(1536, -512, 300), v3(-700, 2048, 5));
        send(OP_CROSS, v3(-700, 2048, 5), v3(1536, -512, 300));
        drain(4);
    endtask

    task automatic mixed_random();
        test_name = "mixed_random";
        fork
            for (int k = 0; k < 40; k++) begin
                send(rand_op(), rand_vec(), rand_vec());
            end
            drain(40);
        join
    endtask

    task automatic back_pressure();
        int n;
        test_name = "back_pressure";
        n = 0;
        while (!cmd_full && n < 64) begin
            send(rand_op(), rand_vec(), rand_vec());
            n++;
        end
        check_flag({test_name, " cmd_full"}, 1'b1, cmd_full);
        drain(n);
    endtask

    task automatic reset_mid_stream();
        int n;
        test_name = "reset_mid_stream";
        n = 0;
        while (!cmd_full && n < 64) begin   // both FIFOs full when reset hits
            send(rand_op(), rand_vec(), rand_vec());
            n++;
        end
        check_flag({test_name, " cmd_full before reset"}, 1'b1, cmd_full);
        repeat (2) @(negedge clock);
        apply_reset();
        clear_scoreboard();
        check_flag({test_name, " result_empty"}, 1'b1, result_empty);
        check_flag({test_name, " cmd_full"}, 1'b0, cmd_full);
        send(OP_CROSS, v3(1024, -2048, 512), v3(300, 1024, -4096));
        drain(1);
    endtask

    initial begin
        int unsigned assert_errors;
        void'($urandom(69));
        reset        = 1'b1;
        cmd_in       = '0;
        cmd_wr_en    = 1'b0;
        result_rd_en = 1'b0;
        clear_scoreboard();
        apply_reset();
        dot_directed();
        cross_directed();
        mixed_random();
        back_pressure();
        reset_mid_stream();
        assert_errors = dut.u_props.fail_count;
        $display("errors: %0d mismatch, %0d scoreboard, %0d assertion",
                 mismatches, other_errors, assert_errors);
        if (mismatches + other_errors + assert_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- sim/vec_engine_properties.sv
module vec_engine_properties import vec_pkg::*; (
    input logic        clock,
    input logic        reset,
    input logic        dot_issue,
    input logic        cross_issue,
    input logic        dot_busy,
    input logic        cross_busy,
    input logic        dot_req,
    input logic        cross_req,
    input vec_result_t dot_result,
    input vec_result_t cross_result,
    input logic        dot_grant,
    input logic        cross_grant,
    input logic        res_wr_en,
    input logic        result_full
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count = 0;

    one_grant: assert property (@(posedge clock) disable iff (reset)
        !(dot_grant && cross_grant))
        else begin
            fail_count++;
            $error("both units granted in one cycle");
        end

    no_write_when_full: assert property (@(posedge clock) disable iff (reset)
        res_wr_en |-> !result_full)
        else begin
            fail_count++;
            $error("result FIFO written while full");
        end

    dot_issue_free: assert property (@(posedge clock) disable iff (reset)
        dot_issue |-> !dot_busy)
        else begin
            fail_count++;
            $error("issue reached a busy dot unit");
        end

    cross_issue_free: assert property (@(posedge clock) disable iff (reset)
        cross_issue |-> !cross_busy)
        else begin
            fail_count++;
            $error("issue reached a busy cross unit");
        end

    dot_hold: assert property (@(posedge clock) disable iff (reset)
        dot_req && !dot_grant |=> dot_req && $stable(dot_result))
        else begin
            fail_count++;
            $error("dot request dropped or changed before grant");
        end

    cross_hold: assert property (@(posedge clock) disable iff (reset)
        cross_req && !cross_grant |=> cross_req && $stable(cross_result))
        else begin
            fail_count++;
            $error("cross request dropped or changed before grant");
        end

endmodule

bind vec_engine vec_engine_properties u_props (
    .clock        (clock),
    .reset        (reset),
    .dot_issue    (dot_issue),
    .cross_issue  (cross_issue),
    .dot_busy     (dot_busy),
    .cross_busy   (cross_busy),
    .dot_req      (dot_req),
    .cross_req    (cross_req),
    .dot_result   (dot_result),
    .cross_result (cross_result),
    .dot_grant    (dot_grant),
    .cross_grant  (cross_grant),
    .res_wr_en    (res_wr_en),
    .result_full  (result_full)
);

//--- src/vec_engine.sv
module vec_engine import vec_pkg::*; #(
    parameter int Q_BITS     = 10,
    parameter int FIFO_DEPTH = 16
) (
    input  logic        clock,
    input  logic        reset,

    input  vec_cmd_t    cmd_in,
    input  logic        cmd_wr_en,
    output logic        cmd_full,

    output vec_result_t result_out,
    input  logic        result_rd_en,
    output logic        result_empty
);

    vec_cmd_t    cmd_head;
    logic        cmd_empty;
    logic        cmd_rd_en;

    vec_cmd_t    issue_cmd;
    logic        dot_issue;
    logic        cross_issue;
    logic        dot_busy;
    logic        cross_busy;

    logic        dot_req;
    logic        cross_req;
    vec_result_t dot_result;
    vec_result_t cross_result;
    logic        dot_grant;
    logic        cross_grant;

    logic        res_wr_en;
    vec_result_t res_data;
    logic        result_full;

    sync_fifo #(
        .payload_t  (vec_cmd_t),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_cmd_fifo (
        .clock (clock),
        .reset (reset),
        .wr_en (cmd_wr_en),
        .din   (cmd_in),
        .full  (cmd_full),
        .rd_en (cmd_rd_en),
        .dout  (cmd_head),
        .empty (cmd_empty)
    );

    op_dispatch u_dispatch (
        .clock       (clock),
        .reset       (reset),
        .cmd_head    (cmd_head),
        .cmd_empty   (cmd_empty),
        .cmd_rd_en   (cmd_rd_en),
        .cmd         (issue_cmd),
        .dot_issue   (dot_issue),
        .cross_issue (cross_issue),
        .dot_busy    (dot_busy),
        .cross_busy  (cross_busy)
    );

    dot_unit #(
        .Q_BITS (Q_BITS)
    ) u_dot (
        .clock  (clock),
        .reset  (reset),
        .issue  (dot_issue),
        .cmd    (issue_cmd),
        .busy   (dot_busy),
        .req    (dot_req),
        .result (dot_result),
        .grant  (dot_grant)
    );

    cross_unit #(
        .Q_BITS (Q_BITS)
    ) u_cross (
        .clock  (clock),
        .reset  (reset),
        .issue  (cross_issue),
        .cmd    (issue_cmd),
        .busy   (cross_busy),
        .req    (cross_req),
        .result (cross_result),
        .grant  (cross_grant)
    );

    result_arbiter u_arbiter (
        .clock        (clock),
        .reset        (reset),
        .dot_req      (dot_req),
        .dot_result   (dot_result),
        .cross_req    (cross_req),
        .cross_result (cross_result),
        .dot_grant    (dot_grant),
        .cross_grant  (cross_grant),
        .result_full  (result_full),
        .wr_en        (res_wr_en),
        .data         (res_data)
    );

    sync_fifo #(
        .payload_t  (vec_result_t),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_result_fifo (
        .clock (clock),
        .reset (reset),
        .wr_en (res_wr_en),
        .din   (res_data),
        .full  (result_full),
        .rd_en (result_rd_en),
        .dout  (result_out),
        .empty (result_empty)
    );

endmodule

//--- src/result_arbiter.sv
module result_arbiter import vec_pkg::*; (
    input  logic        clock,
    input  logic        reset,

    input  logic        dot_req,
    input  vec_result_t dot_result,
    input  logic        cross_req,
    input  vec_result_t cross_result,
    output logic        dot_grant,
    output logic        cross_grant,

    input  logic        result_full,
    output logic        wr_en,
    output vec_result_t data
);

    vec_op_e last_op;       // unit granted most recently
    logic    pick_cross;

    // cross wins alone, or on a tie when dot went last
    assign pick_cross = cross_req && (!dot_req || last_op == OP_DOT);

    assign dot_grant   = !result_full && dot_req && !pick_cross;
    assign cross_grant = !result_full && pick_cross;

    assign wr_en = dot_grant || cross_grant;
    assign data  = pick_cross ? cross_result : dot_result;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            last_op <= OP_CROSS;            // dot wins the first tie
        end else if (dot_grant) begin
            last_op <= OP_DOT;
        end else if (cross_grant) begin
            last_op <= OP_CROSS;
        end
    end

endmodule

//--- src/cross_unit.sv
module cross_unit import vec_pkg::*; #(
    parameter int Q_BITS = 10
) (
    input  logic        clock,
    input  logic        reset,

    input  logic        issue,
    input  vec_cmd_t    cmd,
    output logic        busy,

    output logic        req,
    output vec_result_t result,
    input  logic        grant
);

    enum logic [1:0] {IDLE, SUB, HOLD} state, next_state;

    // stage one products, minuends and subtrahends per output component
    vec3_t      pos_q;
    vec3_t      neg_q;
    logic [7:0] tag_q;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (issue) begin
                    next_state = SUB;
                end
            end
            SUB: next_state = HOLD;
            HOLD: begin
                if (grant) begin
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (state == IDLE && issue) begin
            pos_q.x <= q_mul(cmd.a.y, cmd.b.z, Q_BITS);
            neg_q.x <= q_mul(cmd.a.z, cmd.b.y, Q_BITS);
            pos_q.y <= q_mul(cmd.a.z, cmd.b.x, Q_BITS);
            neg_q.y <= q_mul(cmd.a.x, cmd.b.z, Q_BITS);
            pos_q.z <= q_mul(cmd.a.x, cmd.b.y, Q_BITS);
            neg_q.z <= q_mul(cmd.a.y, cmd.b.x, Q_BITS);
            tag_q   <= cmd.tag;
        end
    end

    // stage two
    always_ff @(posedge clock) begin
        if (state == SUB) begin
            result.op      <= OP_CROSS;
            result.tag     <= tag_q;
            result.value.x <= pos_q.x - neg_q.x;
            result.value.y <= pos_q.y - neg_q.y;
            result.value.z <= pos_q.z - neg_q.z;
        end
    end

    assign req  = (state == HOLD);
    assign busy = (state != IDLE);

endmodule

//--- src/dot_unit.sv
module dot_unit import vec_pkg::*; #(
    parameter int Q_BITS = 10
) (
    input  logic        clock,
    input  logic        reset,

    input  logic        issue,
    input  vec_cmd_t    cmd,
    output logic        busy,

    output logic        req,
    output vec_result_t result,
    input  logic        grant
);

    enum logic {IDLE, HOLD} state, next_state;

    q_t prod_x;
    q_t prod_y;
    q_t prod_z;
    q_t dot_sum;

    assign prod_x = q_mul(cmd.a.x, cmd.b.x, Q_BITS);
    assign prod_y = q_mul(cmd.a.y, cmd.b.y, Q_BITS);
    assign prod_z = q_mul(cmd.a.z, cmd.b.z, Q_BITS);

    assign dot_sum = prod_x + prod_y + prod_z;     // wraps to 32 bits

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (issue) begin
                    next_state = HOLD;
                end
            end
            HOLD: begin
                if (grant) begin
                    next_state = IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (state == IDLE && issue) begin
            result.op      <= OP_DOT;
            result.tag     <= cmd.tag;
            result.value.x <= dot_sum;
            result.value.y <= '0;
            result.value.z <= '0;
        end
    end

    assign req  = (state == HOLD);
    assign busy = (state != IDLE);  // drops the cycle after grant

endmodule

//--- src/op_dispatch.sv
module op_dispatch import vec_pkg::*; (
    input  logic     clock,
    input  logic     reset,

    input  vec_cmd_t cmd_head,
    input  logic     cmd_empty,
    output logic     cmd_rd_en,

    output vec_cmd_t cmd,
    output logic     dot_issue,
    output logic     cross_issue,
    input  logic     dot_busy,
    input  logic     cross_busy
);

    logic [1:0] busy;       // indexed by vec_op_e
    logic [1:0] pending;    // issued last cycle, unit busy not up yet
    logic [1:0] free;
    vec_op_e    head_op;

    assign head_op = cmd_head.op;

    assign busy[OP_DOT]   = dot_busy;
    assign busy[OP_CROSS] = cross_busy;

    assign free = ~busy & ~pending;

    // head of line blocks even if the other unit is idle
    assign cmd_rd_en = !cmd_empty && free[head_op];

    assign dot_issue   = pending[OP_DOT];
    assign cross_issue = pending[OP_CROSS];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pending <= '0;
        end else begin
            pending <= '0;
            if (cmd_rd_en) begin
                pending[head_op] <= 1'b1;
            end
        end
    end

    // issue register, follows the pop by one edge
    always_ff @(posedge clock) begin
        if (cmd_rd_en) begin
            cmd <= cmd_head;
        end
    end

endmodule

//--- src/sync_fifo.sv
module sync_fifo #(
    parameter type payload_t  = logic [7:0],
    parameter int  FIFO_DEPTH = 16
) (
    input  logic     clock,
    input  logic     reset,

    input  logic     wr_en,
    input  payload_t din,
    output logic     full,

    input  logic     rd_en,
    output payload_t dout,
    output logic     empty
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    payload_t           mem [FIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               do_write;
    logic               do_read;

    // wraps at FIFO_DEPTH so depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full     = (count == CNT_W'(FIFO_DEPTH));
    assign empty    = (count == '0);
    assign do_write = wr_en && !full;
    assign do_read  = rd_en && !empty;

    assign dout = mem[rd_ptr];          // show-ahead head entry

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_read) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (do_write) begin
            mem[wr_ptr] <= din;
        end
    end

endmodule

//--- src/vec_pkg.sv
package vec_pkg;

    // one signed fixed-point component, fraction width set by Q_BITS in the units
    typedef logic signed [31:0] q_t;

    typedef struct packed {
        q_t x;
        q_t y;
        q_t z;
    } vec3_t;

    typedef enum logic {
        OP_DOT   = 1'b0,
        OP_CROSS = 1'b1
    } vec_op_e;

    // 201 bits
    typedef struct packed {
        vec_op_e     op;
        logic [7:0]  tag;
        vec3_t       a;
        vec3_t       b;
    } vec_cmd_t;

    // 105 bits, dot results carry the scalar in value.x
    typedef struct packed {
        vec_op_e     op;
        logic [7:0]  tag;
        vec3_t       value;
    } vec_result_t;

    // full 64-bit product, arithmetic shift floors toward minus infinity
    function automatic q_t q_mul(
        input q_t          a,
        input q_t          b,
        input int unsigned shift
    );
        logic signed [63:0] prod;
        prod = a * b;                   // operands sign-extend to 64 bits
        return q_t'(prod >>> shift);    // keep low 32 bits
    endfunction

endpackage
